// File: alu_pkg.sv
// ALU word width, operand and shift-amount types, op-code encoding
package alu_pkg;

	////////////////////
	// widths
	////////////////////

	// operand and result width
	localparam int data_width = 8;

	// one operand or result word
	typedef logic [data_width-1:0] alu_word_t;

	// shift and rotate amount, low bits of operand b
	typedef logic [$clog2(data_width)-1:0] shamt_t;

	// multiplier input, upper half of an operand
	typedef logic [data_width/2-1:0] nibble_t;

	////////////////////
	// op codes
	////////////////////

	// codes 0 and 5 to 7 are no-ops and give a zero result
	typedef enum logic [3:0] {
		op_nop0  = 4'd0,
		op_add   = 4'd1,
		op_sub   = 4'd2,
		op_rsb   = 4'd3,
		op_mulhi = 4'd4,
		op_nop5  = 4'd5,
		op_nop6  = 4'd6,
		op_nop7  = 4'd7,
		op_nor   = 4'd8,
		op_not   = 4'd9,
		op_nand  = 4'd10,
		op_xnor  = 4'd11,
		op_srl   = 4'd12,
		op_sll   = 4'd13,
		op_ror   = 4'd14,
		op_rol   = 4'd15
	} alu_op_t;

endpackage

// File: bus_map_pkg.sv
// APB address width and type, address map constants, bus state encoding
package bus_map_pkg;

	////////////////////
	// address map
	////////////////////

	// word address on the bus
	localparam int apb_addr_width = 10;
	typedef logic [apb_addr_width-1:0] apb_addr_t;

	// memory occupies words 0 up to mem_depth-1
	localparam int mem_depth = 512;

	// register block sits right above the memory
	localparam apb_addr_t addr_op_a    = 10'h200;
	localparam apb_addr_t addr_op_b    = 10'h201;
	localparam apb_addr_t addr_op_code = 10'h202;
	// read only
	localparam apb_addr_t addr_result  = 10'h203;

	////////////////////
	// slave FSM
	////////////////////

	// st_mem_wait is the extra cycle of a memory read
	typedef enum logic [1:0] {
		st_idle,
		st_access,
		st_mem_wait
	} bus_state_t;

endpackage

// File: word_ram.sv
// single-port word memory, write on the edge, registered read data
`timescale 1ns/100ps

module word_ram #(
	parameter int mem_depth = bus_map_pkg::mem_depth
) (
	input  logic                   clk,
	input  logic                   mem_en,
	input  logic                   mem_we,
	input  bus_map_pkg::apb_addr_t mem_addr,
	input  alu_pkg::alu_word_t     mem_wdata,
	output alu_pkg::alu_word_t     mem_rdata
);
	import alu_pkg::*;

	// index bits actually needed, bus address is wider
	localparam int index_width = $clog2(mem_depth);

	// contents undefined until written
	alu_word_t mem [mem_depth];

	logic [index_width-1:0] word_idx;

	assign word_idx = mem_addr[index_width-1:0];

	// one access per enabled cycle
	always_ff @(posedge clk) begin
		if (mem_en) begin
			if (mem_we) begin
				mem[word_idx] <= mem_wdata;
			end else begin
				// read data lands one cycle after the request
				mem_rdata <= mem[word_idx];
			end
		end
		// with mem_en low the output keeps the last word read
	end

endmodule

// File: array_multiplier.sv
// unsigned array multiplier: AND rows plus ripple-carry add layers
`timescale 1ns/100ps

module array_multiplier #(
	parameter int nibble_width = $bits(alu_pkg::nibble_t)
) (
	input  alu_pkg::nibble_t   mcand,
	input  alu_pkg::nibble_t   mplier,
	output alu_pkg::alu_word_t product
);

	// one partial-product row per multiplier bit
	logic [nibble_width-1:0] rows [nibble_width];

	// row i is the multiplicand gated by multiplier bit i
	for (genvar i = 0; i < nibble_width; i++) begin : g_row
		assign rows[i] = mcand & {nibble_width{mplier[i]}};
	end

	// each layer retires one product bit
	always_comb begin
		logic [nibble_width-1:0] pp;
		logic [nibble_width-1:0] sum;
		logic carry;

		// layer zero, nothing to add yet
		product[0] = rows[0][0];
		pp = {1'b0, rows[0][nibble_width-1:1]};

		for (int i = 1; i < nibble_width; i++) begin
			// ripple add of row i onto the running partial product
			carry = 1'b0;
			for (int j = 0; j < nibble_width; j++) begin
				sum[j] = rows[i][j] ^ pp[j] ^ carry;
				carry = (rows[i][j] & pp[j]) | (carry & (rows[i][j] ^ pp[j]));
			end

			// lsb is final, the rest moves down one place
			product[i] = sum[0];
			pp = {carry, sum[nibble_width-1:1]};
		end

		// last partial product fills the upper half
		product[2*nibble_width-1:nibble_width] = pp;
	end

endmodule

// File: shift_rotate.sv
// logical shift and rotate unit, left or right, by 0 to 7 places
`timescale 1ns/100ps

module shift_rotate #(
	parameter int data_width = alu_pkg::data_width
) (
	input  alu_pkg::alu_word_t value,
	input  alu_pkg::shamt_t    amount,
	input  logic               to_right,
	input  logic               rotate,
	output alu_pkg::alu_word_t shifted
);
	import alu_pkg::*;

	// log stages, stage k moves by 2^k when amount[k] is set
	always_comb begin
		logic [data_width-1:0] stage;
		logic [data_width-1:0] wrap;

		stage = value;
		wrap = '0;

		for (int k = 0; k < $bits(shamt_t); k++) begin
			if (amount[k]) begin
				// bits that leave one end, used only when rotating
				if (to_right) begin
					wrap = stage << (data_width - (1 << k));
					stage = stage >> (1 << k);
				end else begin
					wrap = stage >> (data_width - (1 << k));
					stage = stage << (1 << k);
				end

				// plain shifts keep the zero fill
				if (rotate) begin
					stage = stage | wrap;
				end
			end
		end

		shifted = stage;
	end

endmodule

// File: alu_core.sv
// ALU datapath: shared adder, logic ops, nibble multiply, shifter and result select
`timescale 1ns/100ps

module alu_core #(
	parameter int data_width = alu_pkg::data_width
) (
	input  alu_pkg::alu_word_t op_a,
	input  alu_pkg::alu_word_t op_b,
	input  alu_pkg::alu_op_t   op_code,
	output alu_pkg::alu_word_t result
);
	import alu_pkg::*;

	// mulhi uses the upper half of each operand
	localparam int half_width = data_width / 2;

	// adder inputs, shared by add, sub and rsb
	alu_word_t add_x;
	alu_word_t add_y;
	logic      add_cin;
	alu_word_t sum;

	alu_word_t product;
	alu_word_t shifted;
	logic      to_right;
	logic      rotate;

	// subtraction through inversion plus carry-in
	always_comb begin
		add_x = op_a;
		add_y = op_b;
		add_cin = 1'b0;
		if (op_code == op_sub) begin
			// a - b
			add_y = ~op_b;
			add_cin = 1'b1;
		end else if (op_code == op_rsb) begin
			// b - a
			add_x = ~op_a;
			add_cin = 1'b1;
		end
	end

	// carry out dropped, result wraps mod 256
	assign sum = add_x + add_y + alu_word_t'(add_cin);

	array_multiplier #(
		.nibble_width(half_width)
	) i_mul (
		.mcand  (op_a[data_width-1 -: half_width]),
		.mplier (op_b[data_width-1 -: half_width]),
		.product(product)
	);

	// shift direction and mode straight from the op code
	assign to_right = (op_code == op_srl) || (op_code == op_ror);
	assign rotate   = (op_code == op_ror) || (op_code == op_rol);

	shift_rotate #(
		.data_width(data_width)
	) i_shift (
		.value   (op_a),
		.amount  (op_b[$bits(shamt_t)-1:0]),
		.to_right(to_right),
		.rotate  (rotate),
		.shifted (shifted)
	);

	// result select
	always_comb begin
		case (op_code)
			op_add, op_sub, op_rsb: result = sum;
			op_mulhi:               result = product;
			op_nor:                 result = ~(op_a | op_b);
			op_not:                 result = ~op_b;
			op_nand:                result = ~(op_a & op_b);
			op_xnor:                result = op_a ~^ op_b;
			op_srl, op_sll:         result = shifted;
			op_ror, op_rol:         result = shifted;
			// no-op codes read as zero
			op_nop0, op_nop5:       result = '0;
			op_nop6, op_nop7:       result = '0;
		endcase
	end

endmodule

// File: apb_regs.sv
// APB slave: address decode, operand and op registers, read mux, memory wait state
`timescale 1ns/100ps

module apb_regs (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  bus_map_pkg::apb_addr_t paddr,
	input  alu_pkg::alu_word_t     pwdata,
	output alu_pkg::alu_word_t     prdata,
	output logic                   pready,
	output logic                   pslverr,
	input  alu_pkg::alu_word_t     alu_result,
	output alu_pkg::alu_word_t     op_a,
	output alu_pkg::alu_word_t     op_b,
	output alu_pkg::alu_op_t       op_code,
	output logic                   mem_en,
	output logic                   mem_we,
	output bus_map_pkg::apb_addr_t mem_addr,
	output alu_pkg::alu_word_t     mem_wdata,
	input  alu_pkg::alu_word_t     mem_rdata
);
	import alu_pkg::*;
	import bus_map_pkg::*;

	bus_state_t state;

	// address decode
	logic      hit_mem;
	logic      hit_a;
	logic      hit_b;
	logic      hit_code;
	logic      hit_result;
	logic      addr_err;
	alu_word_t reg_rdata;

	// read data captured in setup for non-memory transfers
	alu_word_t rd_data_q;
	// steers the RAM output onto prdata
	logic      rd_from_mem;

	logic      setup;
	logic      done;

	assign setup = psel && !penable;
	// completing edge of the transfer
	assign done  = psel && penable && pready;

	// paddr is held by the master for the whole transfer
	assign hit_mem    = paddr < apb_addr_t'(mem_depth);
	assign hit_a      = (paddr == addr_op_a);
	assign hit_b      = (paddr == addr_op_b);
	assign hit_code   = (paddr == addr_op_code);
	assign hit_result = (paddr == addr_result);

	// unmapped address, or a write to the read-only result
	assign addr_err = !(hit_mem || hit_a || hit_b || hit_code || hit_result)
		|| (pwrite && hit_result);

	// register read mux, unmapped reads give 0
	always_comb begin
		case (paddr)
			addr_op_a:    reg_rdata = op_a;
			addr_op_b:    reg_rdata = op_b;
			addr_op_code: reg_rdata = alu_word_t'(op_code);
			addr_result:  reg_rdata = alu_result;
			default:      reg_rdata = '0;
		endcase
	end

	//////////////////////
	// slave FSM
	//////////////////////

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
			pready <= 1'b0;
			pslverr <= 1'b0;
			rd_data_q <= '0;
			rd_from_mem <= 1'b0;
			mem_en <= 1'b0;
			mem_we <= 1'b0;
			op_a <= '0;
			op_b <= '0;
			op_code <= op_nop0;
		end else begin
			case (state)
				st_idle: begin
					if (setup) begin
						// RAM request goes out with the access phase
						if (hit_mem) begin
							mem_en <= 1'b1;
							mem_we <= pwrite;
						end
						if (hit_mem && !pwrite) begin
							// pready stays low for one access cycle
							rd_from_mem <= 1'b1;
							state <= st_mem_wait;
						end else begin
							pready <= 1'b1;
							pslverr <= addr_err;
							rd_data_q <= pwrite ? '0 : reg_rdata;
							state <= st_access;
						end
					end
				end
				st_mem_wait: begin
					// RAM has sampled the read, data valid next cycle
					mem_en <= 1'b0;
					pready <= 1'b1;
					state <= st_access;
				end
				st_access: begin
					if (done) begin
						// register writes land on the completing edge
						if (pwrite && hit_a) begin
							op_a <= pwdata;
						end
						if (pwrite && hit_b) begin
							op_b <= pwdata;
						end
						if (pwrite && hit_code) begin
							op_code <= alu_op_t'(pwdata[$bits(alu_op_t)-1:0]);
						end
						mem_en <= 1'b0;
						mem_we <= 1'b0;
						pready <= 1'b0;
						pslverr <= 1'b0;
						rd_from_mem <= 1'b0;
						state <= st_idle;
					end
				end
				default: state <= st_idle;
			endcase
		end
	end

	// memory address and write data, latched in setup
	always_ff @(posedge clk) begin
		if (state == st_idle && setup) begin
			mem_addr <= paddr;
			mem_wdata <= pwdata;
		end
	end

	assign prdata = rd_from_mem ? mem_rdata : rd_data_q;

endmodule

// File: alu_apb_top.sv
// top level: APB slave, word memory and ALU datapath
`timescale 1ns/100ps

module alu_apb_top #(
	parameter int data_width = alu_pkg::data_width,
	parameter int mem_depth  = bus_map_pkg::mem_depth
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  bus_map_pkg::apb_addr_t paddr,
	input  alu_pkg::alu_word_t     pwdata,
	output alu_pkg::alu_word_t     prdata,
	output logic                   pready,
	output logic                   pslverr
);
	import alu_pkg::*;
	import bus_map_pkg::*;

	// slave to ALU
	alu_word_t op_a;
	alu_word_t op_b;
	alu_op_t   op_code;
	alu_word_t alu_result;

	// slave to memory
	logic      mem_en;
	logic      mem_we;
	apb_addr_t mem_addr;
	alu_word_t mem_wdata;
	alu_word_t mem_rdata;

	apb_regs i_regs (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.paddr     (paddr),
		.pwdata    (pwdata),
		.prdata    (prdata),
		.pready    (pready),
		.pslverr   (pslverr),
		.alu_result(alu_result),
		.op_a      (op_a),
		.op_b      (op_b),
		.op_code   (op_code),
		.mem_en    (mem_en),
		.mem_we    (mem_we),
		.mem_addr  (mem_addr),
		.mem_wdata (mem_wdata),
		.mem_rdata (mem_rdata)
	);

	word_ram #(
		.mem_depth(mem_depth)
	) i_ram (
		.clk      (clk),
		.mem_en   (mem_en),
		.mem_we   (mem_we),
		.mem_addr (mem_addr),
		.mem_wdata(mem_wdata),
		.mem_rdata(mem_rdata)
	);

	// purely combinational, result follows the registers
	alu_core #(
		.data_width(data_width)
	) i_alu (
		.op_a   (op_a),
		.op_b   (op_b),
		.op_code(op_code),
		.result (alu_result)
	);

endmodule

// File: tb_clock.sv
// testbench clock with a 40 ns period and the reset pulse
`timescale 1ns/100ps

module tb_clock (
	output logic clk,
	output logic rst_n
);

	// 20 ns high, 20 ns low
	localparam int half_period = 20;
	localparam int reset_cycles = 16;

	initial begin
		clk = 1'b0;
		forever begin
			#half_period;
			clk = ~clk;
		end
	end

	// reset held low, then released on a rising edge
	initial begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// File: tb_checker.sv
// bus monitor comparing completed APB transfers and their wait states with expected values
`timescale 1ns/100ps

module tb_checker (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic                   pready,
	input  bus_map_pkg::apb_addr_t paddr,
	input  alu_pkg::alu_word_t     prdata,
	input  logic                   pslverr,
	input  int                     test_id,
	input  alu_pkg::alu_word_t     exp_rdata,
	input  logic                   exp_err,
	output int                     pass_count,
	output int                     fail_count
);
	import bus_map_pkg::*;

	// access cycles with pready low in the current transfer
	int wait_cycles;

	////////////////////
	// compare
	////////////////////

	// sample on the falling edge where the bus signals are settled
	// psel, penable and pready all high means the next rising edge completes
	always @(negedge clk) begin
		logic bad;
		int   exp_waits;

		bad = 1'b0;
		exp_waits = 0;
		if (!rst_n) begin
			pass_count <= 0;
			fail_count <= 0;
			wait_cycles = 0;
		end else if (!psel || !penable) begin
			// no access phase yet so the count starts over
			wait_cycles = 0;
		end else if (!pready) begin
			wait_cycles++;
		end else begin
			// read data only counts on reads
			if (!pwrite && prdata !== exp_rdata) begin
				$display("CHECK FAILED time %0t: prdata expected %h actual %h",
					$time, exp_rdata, prdata);
				bad = 1'b1;
			end
			if (pslverr !== exp_err) begin
				$display("CHECK FAILED time %0t: pslverr expected %b actual %b",
					$time, exp_err, pslverr);
				bad = 1'b1;
			end

			// a memory read takes exactly one wait state, all else none
			if (!pwrite && int'(paddr) < mem_depth) begin
				exp_waits = 1;
			end
			if (wait_cycles != exp_waits) begin
				$display("CHECK FAILED time %0t: pready wait states expected %0d actual %0d",
					$time, exp_waits, wait_cycles);
				bad = 1'b1;
			end
			wait_cycles = 0;

			// one line per finished transfer
			if (bad) begin
				$display("test %0d: %s at %h failed", test_id,
					pwrite ? "write" : "read", paddr);
				fail_count <= fail_count + 1;
			end else begin
				$display("test %0d: %s at %h ok", test_id,
					pwrite ? "write" : "read", paddr);
				pass_count <= pass_count + 1;
			end
		end
	end

endmodule

// File: tb_top.sv
// testbench top with case file reader, APB master with idle gaps, totals and verdict
`timescale 1ns/100ps

module tb_top;
	import alu_pkg::*;
	import bus_map_pkg::*;

	// cycles allowed for pready and for reset release
	localparam int ready_limit = 16;
	localparam int reset_limit = 64;

	logic      clk;
	logic      rst_n;
	logic      psel;
	logic      penable;
	logic      pwrite;
	apb_addr_t paddr;
	alu_word_t pwdata;
	alu_word_t prdata;
	logic      pready;
	logic      pslverr;

	// expectations handed to the checker
	int        test_id;
	alu_word_t exp_rdata;
	logic      exp_err;
	int        pass_count;
	int        fail_count;

	int        n_cases;
	int        n_timeouts;
	int        n_bad_lines;
	logic      run_ok;

	tb_clock i_clock (
		.clk  (clk),
		.rst_n(rst_n)
	);

	alu_apb_top #(
		.data_width(data_width),
		.mem_depth (mem_depth)
	) i_dut (
		.clk    (clk),
		.rst_n  (rst_n),
		.psel   (psel),
		.penable(penable),
		.pwrite (pwrite),
		.paddr  (paddr),
		.pwdata (pwdata),
		.prdata (prdata),
		.pready (pready),
		.pslverr(pslverr)
	);

	tb_checker i_checker (
		.clk       (clk),
		.rst_n     (rst_n),
		.psel      (psel),
		.penable   (penable),
		.pwrite    (pwrite),
		.pready    (pready),
		.paddr     (paddr),
		.prdata    (prdata),
		.pslverr   (pslverr),
		.test_id   (test_id),
		.exp_rdata (exp_rdata),
		.exp_err   (exp_err),
		.pass_count(pass_count),
		.fail_count(fail_count)
	);

	////////////////////
	// APB master
	////////////////////

	// setup, access, then wait for pready up to ready_limit cycles
	task automatic run_transfer(
		input  logic      is_write,
		input  apb_addr_t addr,
		input  alu_word_t wdata,
		output logic      timed_out
	);
		int   waited;
		logic seen;

		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= is_write;
		paddr <= addr;
		pwdata <= wdata;

		@(posedge clk);
		penable <= 1'b1;

		waited = 0;
		seen = 1'b0;
		timed_out = 1'b0;
		while (!seen && !timed_out) begin
			@(negedge clk);
			if (pready) begin
				seen = 1'b1;
			end else begin
				waited++;
				if (waited >= ready_limit) begin
					timed_out = 1'b1;
				end
			end
		end

		// bus goes idle on the completing edge
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		int          fd;
		int          n;
		int          waited;
		int          gap;
		string       line;
		byte         kind_ch;
		apb_addr_t   f_addr;
		alu_word_t   f_wdata;
		alu_word_t   f_rdata;
		logic        f_err;
		logic        timed_out;

		// bus idle from time zero
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		test_id = 0;
		exp_rdata = '0;
		exp_err = 1'b0;
		n_cases = 0;
		n_timeouts = 0;
		n_bad_lines = 0;
		run_ok = 1'b1;
		void'($urandom(32'h732c_1c5a));

		waited = 0;
		while (!rst_n && waited < reset_limit) begin
			@(posedge clk);
			waited++;
		end

		if (!rst_n) begin
			$display("error: reset was never released");
			run_ok = 1'b0;
		end else begin
			fd = $fopen("alu_apb_cases.txt", "r");
			if (fd == 0) begin
				$display("error: could not open alu_apb_cases.txt");
				run_ok = 1'b0;
			end else begin
				while (!$feof(fd)) begin
					line = "";
					n = $fgets(line, fd);
					// skip blank and comment lines
					if (n > 2 && line.getc(0) != "#") begin
						kind_ch = line.getc(0);
						n = $sscanf(line.substr(2, line.len() - 1), "%h %h %h %h",
							f_addr, f_wdata, f_rdata, f_err);
						if (n != 4 || (kind_ch != "R" && kind_ch != "W")) begin
							$display("error: malformed case line %s", line);
							n_bad_lines++;
						end else begin
							n_cases++;
							test_id = n_cases;
							exp_rdata = f_rdata;
							exp_err = f_err;
							run_transfer(kind_ch == "W", f_addr, f_wdata, timed_out);
							if (timed_out) begin
								$display("test %0d: no pready within %0d cycles, transfer dropped",
									test_id, ready_limit);
								n_timeouts++;
							end
							// 0 to 3 idle cycles before the next transfer
							gap = $urandom % 4;
							repeat (gap) @(posedge clk);
						end
					end
				end
				$fclose(fd);
			end
		end

		// let the checker counters settle
		repeat (2) @(posedge clk);
		$display("totals: %0d tests, %0d passed, %0d failed, %0d timed out, %0d bad lines",
			n_cases, pass_count, fail_count, n_timeouts, n_bad_lines);
		if (run_ok && n_cases > 0 && fail_count == 0 && n_timeouts == 0
			&& n_bad_lines == 0 && pass_count == n_cases) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

// File: alu_apb_cases.txt
# kind addr wdata expected_rdata expected_pslverr
# values in hex and expected_rdata only checked on reads
# registers after reset
R 200 00 00 0
R 201 00 00 0
R 202 00 00 0
R 203 00 00 0
# memory corners
W 000 a5 00 0
W 001 5a 00 0
W 0ff c3 00 0
W 1ff 3c 00 0
R 000 00 a5 0
R 001 00 5a 0
R 0ff 00 c3 0
R 1ff 00 3c 0
# a 3c and b d2
W 200 3c 00 0
W 201 d2 00 0
W 202 01 00 0
R 203 00 0e 0
W 202 02 00 0
R 203 00 6a 0
W 202 03 00 0
R 203 00 96 0
W 202 04 00 0
R 203 00 27 0
W 202 08 00 0
R 203 00 01 0
W 202 09 00 0
R 203 00 2d 0
W 202 0a 00 0
R 203 00 ef 0
W 202 0b 00 0
R 203 00 11 0
W 202 00 00 0
R 203 00 00 0
W 202 05 00 0
R 203 00 00 0
W 202 06 00 0
R 203 00 00 0
W 202 07 00 0
R 203 00 00 0
# a ff and b f7
W 200 ff 00 0
W 201 f7 00 0
W 202 04 00 0
R 203 00 e1 0
W 202 01 00 0
R 203 00 f6 0
# shifts and rotates of b5
W 200 b5 00 0
W 202 0c 00 0
W 201 00 00 0
R 203 00 b5 0
W 201 03 00 0
R 203 00 16 0
W 201 ff 00 0
R 203 00 01 0
W 201 f9 00 0
R 203 00 5a 0
W 202 0d 00 0
R 203 00 6a 0
W 201 03 00 0
R 203 00 a8 0
W 201 07 00 0
R 203 00 80 0
W 201 00 00 0
R 203 00 b5 0
W 202 0e 00 0
R 203 00 b5 0
W 201 03 00 0
R 203 00 b6 0
W 201 ff 00 0
R 203 00 6b 0
W 202 0f 00 0
R 203 00 da 0
W 201 03 00 0
R 203 00 ad 0
W 201 00 00 0
R 203 00 b5 0
# bus errors leave the registers alone
W 203 55 00 1
W 300 55 00 1
R 300 00 00 1
R 200 00 b5 0
R 201 00 00 0
R 202 00 0f 0
R 203 00 b5 0

// File: alu_apb.f
alu_pkg.sv
bus_map_pkg.sv
word_ram.sv
array_multiplier.sv
shift_rotate.sv
alu_core.sv
apb_regs.sv
alu_apb_top.sv
tb_clock.sv
tb_checker.sv
tb_top.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps -j 0
TOP       = tb_top
FILELIST  = alu_apb.f
SIM       = obj_dir/V$(TOP)
PASS_MSG  = ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
